// File: verilog.f
hw/mp3_pkg.sv
hw/header_if.sv
hw/header_finder.sv
hw/frame_demux.sv
hw/side_info_parser.sv
hw/mp3_front_top.sv
testbench/mp3_front_checker.sv
testbench/tb_mp3_front.sv

// File: Bender.yml
package:
  name: mp3_front

sources:
  - files:
      - hw/mp3_pkg.sv
      - hw/header_if.sv
      - hw/header_finder.sv
      - hw/frame_demux.sv
      - hw/side_info_parser.sv
      - hw/mp3_front_top.sv
  - target: test
    files:
      - testbench/mp3_front_checker.sv
      - testbench/tb_mp3_front.sv

// File: testbench/tb_mp3_front.sv
`default_nettype none
`timescale 1ns/1ps

module tb_mp3_front;

  localparam int clk_period_ns = 10;
  localparam int max_frames    = 16;
  localparam int max_frame_len = 1441;  // 320 kbps at 32 kHz, padded
  // One idle cycle at most per byte, then a margin of two
  localparam int watchdog_ns   = max_frames * max_frame_len * 2 * 2 * clk_period_ns;

  logic        clk_100mhz;
  logic        sys_rst;
  logic [7:0]  byte_in;
  logic        byte_valid;
  logic [1:0]  gc_sel;
  logic        frame_start;
  logic [1:0]  mode;
  logic [1:0]  mode_ext;
  logic        prot;
  logic [10:0] frame_size;
  logic [7:0]  md_byte;
  logic        md_valid;
  logic        si_valid;
  logic [8:0]  main_data_begin;
  logic [7:0]  scfsi;
  logic [11:0] gc_part2_3_length;
  logic [8:0]  gc_big_values;
  logic [7:0]  gc_global_gain;
  logic        gc_window_switching_flag;
  logic [1:0]  gc_block_type;
  logic [4:0]  gc_table_select0;
  logic [3:0]  gc_region0_count;

  logic [31:0] seed;
  logic [7:0]  tx_q[$];
  logic [7:0]  md_exp[$];
  logic [7:0]  md_got[$];
  logic [15:0] hdr_exp[$];    // {prot, mode, mode_ext, frame_size}
  logic [15:0] hdr_got[$];
  logic [8:0]  mdb_exp[$];
  logic [8:0]  mdb_got[$];
  int          err_count;
  int          test_count;
  int          failed_tests;
  int          assert_fails;
  int          kbps_table [16] = '{0, 32, 40, 48, 56, 64, 80, 96, 112, 128, 160, 192,
                                   224, 256, 320, 0};

  mp3_front_top dut (.*);

  initial begin
    clk_100mhz = 1'b0;
    forever #(clk_period_ns / 2) clk_100mhz = ~clk_100mhz;
  end

  initial begin
    #(watchdog_ns);
    $display("Watchdog expired before the tests finished");
    $display("test failed");
    $finish;
  end

  // Output monitor, samples registered outputs on the rising edge
  always @(posedge clk_100mhz) begin
    if (frame_start)
      hdr_got.push_back({prot, mode, mode_ext, frame_size});
    if (si_valid)
      mdb_got.push_back(main_data_begin);
    if (md_valid)
      md_got.push_back(md_byte);
  end

  ////////////////////////////////////////
  // Stimulus helpers

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return {seed[15:0], seed[31:16]};   // High bits carry the better randomness
  endfunction

  function automatic logic [255:0] random_si();
    logic [255:0] si;
    for (int i = 0; i < 8; i++)
      si[i*32 +: 32] = next_rand();
    return si;
  endfunction

  function automatic logic [7:0] random_md();
    logic [31:0] r;
    r = next_rand();
    return (r[7:0] == 8'hff) ? 8'hfe : r[7:0];  // No accidental sync at a frame end
  endfunction

  function automatic logic [31:0] make_header(input logic [1:0] layer, input logic [3:0] br,
      input logic [1:0] sr, input logic pad, input logic prot_en, input logic [1:0] md,
      input logic [1:0] md_ext);
    return {11'h7ff, 2'b11, layer, ~prot_en, br, sr, pad, 1'b0, md, md_ext, 4'b0000};
  endfunction

  function automatic logic [10:0] expected_size(input logic [3:0] br, input logic [1:0] sr,
      input logic pad);
    int k;
    k = kbps_table[br];
    if (sr == 2'b01)
      return 11'(3 * k + pad);          // 48 kHz
    return 11'((9 * k) / 2 + pad);      // 32 kHz
  endfunction

  task automatic add_word(input logic [31:0] w);
    for (int i = 3; i >= 0; i--)
      tx_q.push_back(w[i*8 +: 8]);
  endtask

  task automatic add_junk(input int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      r = next_rand();
      tx_q.push_back(r[7:0] & 8'h7f);   // Never a sync byte
    end
  endtask

  task automatic add_frame(input logic [3:0] br, input logic [1:0] sr, input logic pad,
      input logic prot_en, input logic [255:0] si, input logic plant);
    logic [31:0] hdr;
    logic [31:0] r;
    logic [1:0]  md;
    logic [10:0] size;
    logic [7:0]  b;
    int          md_len;
    r      = next_rand();
    md     = (r[1:0] == 2'b11) ? 2'b01 : r[1:0];   // Stereo modes only
    hdr    = make_header(2'b01, br, sr, pad, prot_en, md, r[3:2]);
    size   = expected_size(br, sr, pad);
    md_len = size - 4 - 32 - (prot_en ? 2 : 0);
    add_word(hdr);
    if (prot_en) begin
      tx_q.push_back(r[15:8]);
      tx_q.push_back(r[23:16]);
    end
    for (int i = 31; i >= 0; i--)
      tx_q.push_back(si[i*8 +: 8]);
    for (int i = 0; i < md_len; i++) begin
      b = random_md();
      if (plant && i < 4)
        b = hdr[(3 - i)*8 +: 8];          // Copy of a valid header inside main data
      tx_q.push_back(b);
      md_exp.push_back(b);
    end
    hdr_exp.push_back({prot_en, md, r[3:2], size});
    mdb_exp.push_back(si[255:247]);
  endtask

  task automatic send_stream(input logic gaps);
    logic [31:0] r;
    while (tx_q.size() > 0) begin
      @(posedge clk_100mhz);
      byte_in    <= tx_q.pop_front();
      byte_valid <= 1'b1;
      r = next_rand();
      if (gaps && r[2:0] == 3'd0) begin
        @(posedge clk_100mhz);
        byte_valid <= 1'b0;
      end
    end
    @(posedge clk_100mhz);
    byte_valid <= 1'b0;
    repeat (3) @(posedge clk_100mhz);    // Strobes trail their byte by one cycle
  endtask

  task automatic clear_queues();
    md_exp.delete();
    md_got.delete();
    hdr_exp.delete();
    hdr_got.delete();
    mdb_exp.delete();
    mdb_got.delete();
  endtask

  ////////////////////////////////////////
  // Checking

  task automatic report_mismatch(input string name, input logic [31:0] got,
      input logic [31:0] exp);
    err_count++;
    $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
  endtask

  task automatic count_error(input string what, input int got, input int exp);
    err_count++;
    $display("Saw %0d %s where %0d were expected", got, what, exp);
  endtask

  task automatic compare_results();
    if (hdr_got.size() != hdr_exp.size())
      count_error("frame starts", hdr_got.size(), hdr_exp.size());
    if (mdb_got.size() != mdb_exp.size())
      count_error("si_valid pulses", mdb_got.size(), mdb_exp.size());
    if (md_got.size() != md_exp.size())
      count_error("main-data bytes", md_got.size(), md_exp.size());
    for (int i = 0; i < hdr_exp.size() && i < hdr_got.size(); i++) begin
      if (hdr_got[i][10:0] !== hdr_exp[i][10:0])
        report_mismatch("frame_size", hdr_got[i][10:0], hdr_exp[i][10:0]);
      if (hdr_got[i][12:11] !== hdr_exp[i][12:11])
        report_mismatch("mode_ext", hdr_got[i][12:11], hdr_exp[i][12:11]);
      if (hdr_got[i][14:13] !== hdr_exp[i][14:13])
        report_mismatch("mode", hdr_got[i][14:13], hdr_exp[i][14:13]);
      if (hdr_got[i][15] !== hdr_exp[i][15])
        report_mismatch("prot", hdr_got[i][15], hdr_exp[i][15]);
    end
    for (int i = 0; i < mdb_exp.size() && i < mdb_got.size(); i++)
      if (mdb_got[i] !== mdb_exp[i])
        report_mismatch("main_data_begin", mdb_got[i], mdb_exp[i]);
    for (int i = 0; i < md_exp.size() && i < md_got.size(); i++)
      if (md_got[i] !== md_exp[i])
        report_mismatch("md_byte", md_got[i], md_exp[i]);
  endtask

  // Records sit in stream order after 20 bits of frame-level fields
  task automatic check_records(input logic [255:0] si);
    logic [58:0] rec;
    logic [21:0] region;
    logic [1:0]  bt;
    logic [4:0]  ts0;
    logic [3:0]  r0c;
    if (main_data_begin !== si[255:247])
      report_mismatch("main_data_begin", main_data_begin, si[255:247]);
    if (scfsi !== si[243:236])
      report_mismatch("scfsi", scfsi, si[243:236]);
    for (int i = 0; i < 4; i++) begin
      @(posedge clk_100mhz);
      gc_sel <= 2'(i);
      @(posedge clk_100mhz);
      rec    = si[235 - 59*i -: 59];
      region = rec[24:3];
      bt     = rec[25] ? region[21:20] : 2'd0;
      ts0    = rec[25] ? region[18:14] : region[21:17];
      r0c    = rec[25] ? 4'd7 : region[6:3];
      if (gc_part2_3_length !== rec[58:47])
        report_mismatch("gc_part2_3_length", gc_part2_3_length, rec[58:47]);
      if (gc_big_values !== rec[46:38])
        report_mismatch("gc_big_values", gc_big_values, rec[46:38]);
      if (gc_global_gain !== rec[37:30])
        report_mismatch("gc_global_gain", gc_global_gain, rec[37:30]);
      if (gc_window_switching_flag !== rec[25])
        report_mismatch("gc_window_switching_flag", gc_window_switching_flag, rec[25]);
      if (gc_block_type !== bt)
        report_mismatch("gc_block_type", gc_block_type, bt);
      if (gc_table_select0 !== ts0)
        report_mismatch("gc_table_select0", gc_table_select0, ts0);
      if (gc_region0_count !== r0c)
        report_mismatch("gc_region0_count", gc_region0_count, r0c);
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    test_count++;
    if (err_count == errs_before) begin
      $display("%s: ok", name);
    end else begin
      failed_tests++;
      $display("%s: %0d errors", name, err_count - errs_before);
    end
  endtask

  ////////////////////////////////////////
  // Directed tests

  task automatic run_header_decode();
    int errs;
    errs = err_count;
    clear_queues();
    add_frame(4'd9, 2'b01, 1'b0, 1'b0, random_si(), 1'b0);   // 128 kbps, 48 kHz
    add_frame(4'd14, 2'b10, 1'b1, 1'b1, random_si(), 1'b0);  // 320 kbps, 32 kHz
    add_frame(4'd1, 2'b01, 1'b1, 1'b0, random_si(), 1'b0);
    add_frame(4'd3, 2'b10, 1'b0, 1'b1, random_si(), 1'b0);
    add_frame(4'd11, 2'b10, 1'b1, 1'b0, random_si(), 1'b0);
    send_stream(1'b1);
    compare_results();
    finish_test("header_decode", errs);
  endtask

  task automatic run_side_info();
    logic [255:0] si;
    int           errs;
    errs    = err_count;
    clear_queues();
    si      = random_si();
    si[202] = 1'b1;   // gr0ch0 switched
    si[143] = 1'b0;   // gr0ch1 long
    si[84]  = 1'b1;
    si[25]  = 1'b0;
    add_frame(4'd5, 2'b01, 1'b0, 1'b0, si, 1'b0);
    send_stream(1'b1);
    compare_results();
    check_records(si);
    finish_test("side_info", errs);
  endtask

  task automatic run_crc_skip();
    int errs;
    errs = err_count;
    clear_queues();
    add_frame(4'd7, 2'b01, 1'b0, 1'b1, random_si(), 1'b0);
    add_frame(4'd7, 2'b01, 1'b0, 1'b0, random_si(), 1'b0);
    send_stream(1'b1);
    compare_results();
    finish_test("crc_skip", errs);
  endtask

  task automatic run_rejection();
    int errs;
    errs = err_count;
    clear_queues();
    add_junk(64);
    add_word(make_header(2'b01, 4'd9, 2'b00, 1'b0, 1'b0, 2'b00, 2'b00));  // 44.1 kHz
    add_junk(40);
    add_word(make_header(2'b01, 4'd9, 2'b01, 1'b0, 1'b0, 2'b11, 2'b00));  // Mono
    add_junk(40);
    add_word(make_header(2'b10, 4'd9, 2'b01, 1'b0, 1'b0, 2'b00, 2'b00));  // Layer II
    add_junk(40);
    add_frame(4'd6, 2'b10, 1'b0, 1'b0, random_si(), 1'b0);
    send_stream(1'b1);
    compare_results();
    finish_test("rejection", errs);
  endtask

  task automatic run_back_to_back();
    logic [255:0] si;
    int           errs;
    errs = err_count;
    clear_queues();
    si   = random_si();
    add_frame(4'd2, 2'b01, 1'b0, 1'b0, random_si(), 1'b1);
    add_frame(4'd4, 2'b10, 1'b1, 1'b1, si, 1'b1);
    send_stream(1'b0);
    compare_results();
    check_records(si);
    finish_test("back_to_back", errs);
  endtask

  initial begin
    seed         = 32'hb458_c998;
    err_count    = 0;
    test_count   = 0;
    failed_tests = 0;
    assert_fails = 0;
    sys_rst      = 1'b1;
    byte_in      = 8'h00;
    byte_valid   = 1'b0;
    gc_sel       = 2'd0;
    repeat (8) @(posedge clk_100mhz);
    sys_rst <= 1'b0;

    run_header_decode();
    run_side_info();
    run_crc_skip();
    run_rejection();
    run_back_to_back();

    assert_fails = dut.demux.strobe_check.fail_count;
    $display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
             test_count, failed_tests, err_count, assert_fails);
    if (err_count == 0 && assert_fails == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/mp3_front_checker.sv
`default_nettype none
`timescale 1ns/1ps

module mp3_front_checker (
  input wire clk_100mhz,
  input wire sys_rst,
  input wire frame_start,
  input wire si_strobe,
  input wire md_strobe
);

  int fail_count = 0;  // Failed assertions so far

  // A byte belongs to one section at most
  strobe_exclusive: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    !(si_strobe && md_strobe))
    else begin
      $error("si_strobe and md_strobe high in the same cycle");
      fail_count++;
    end

  single_start: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    frame_start |=> !frame_start)
    else begin
      $error("frame_start high in two consecutive cycles");
      fail_count++;
    end

  quiet_after_reset: assert property (@(posedge clk_100mhz)
    sys_rst |=> !(frame_start || si_strobe || md_strobe))
    else begin
      $error("Strobe high in the cycle after reset");
      fail_count++;
    end

endmodule

bind frame_demux mp3_front_checker strobe_check (
  .clk_100mhz  (clk_100mhz),
  .sys_rst     (sys_rst),
  .frame_start (frame_start),
  .si_strobe   (si_strobe),
  .md_strobe   (md_strobe)
);

`default_nettype wire

// File: hw/mp3_front_top.sv
`default_nettype none
`timescale 1ns/1ps

module mp3_front_top (
  input  wire         clk_100mhz,
  input  wire         sys_rst,
  input  wire  [7:0]  byte_in,
  input  wire         byte_valid,
  input  wire  [1:0]  gc_sel,
  output logic        frame_start,
  output logic [1:0]  mode,
  output logic [1:0]  mode_ext,
  output logic        prot,
  output logic [10:0] frame_size,
  output logic [7:0]  md_byte,
  output logic        md_valid,
  output logic        si_valid,
  output logic [8:0]  main_data_begin,
  output logic [7:0]  scfsi,
  output logic [11:0] gc_part2_3_length,
  output logic [8:0]  gc_big_values,
  output logic [7:0]  gc_global_gain,
  output logic        gc_window_switching_flag,
  output logic [1:0]  gc_block_type,
  output logic [4:0]  gc_table_select0,
  output logic [3:0]  gc_region0_count
);

  logic si_strobe;

  header_if hdr_bus ();

  header_finder finder (
    .clk_100mhz (clk_100mhz),
    .sys_rst    (sys_rst),
    .byte_in    (byte_in),
    .byte_valid (byte_valid),
    .hdr        (hdr_bus.finder)
  );

  // Section byte bus doubles as the main-data output
  frame_demux demux (
    .clk_100mhz  (clk_100mhz),
    .sys_rst     (sys_rst),
    .byte_in     (byte_in),
    .byte_valid  (byte_valid),
    .hdr         (hdr_bus.demux),
    .frame_start (frame_start),
    .mode        (mode),
    .mode_ext    (mode_ext),
    .prot        (prot),
    .frame_size  (frame_size),
    .sec_byte    (md_byte),
    .si_strobe   (si_strobe),
    .md_strobe   (md_valid)
  );

  side_info_parser si_parser (
    .clk_100mhz               (clk_100mhz),
    .sys_rst                  (sys_rst),
    .sec_byte                 (md_byte),
    .si_strobe                (si_strobe),
    .gc_sel                   (gc_sel),
    .si_valid                 (si_valid),
    .main_data_begin          (main_data_begin),
    .scfsi                    (scfsi),
    .gc_part2_3_length        (gc_part2_3_length),
    .gc_big_values            (gc_big_values),
    .gc_global_gain           (gc_global_gain),
    .gc_window_switching_flag (gc_window_switching_flag),
    .gc_block_type            (gc_block_type),
    .gc_table_select0         (gc_table_select0),
    .gc_region0_count         (gc_region0_count)
  );

endmodule

`default_nettype wire

// File: hw/side_info_parser.sv
`default_nettype none
`timescale 1ns/1ps

module side_info_parser (
  input  wire         clk_100mhz,
  input  wire         sys_rst,
  input  wire  [7:0]  sec_byte,
  input  wire         si_strobe,
  input  wire  [1:0]  gc_sel,      // {granule, channel}
  output logic        si_valid,
  output logic [8:0]  main_data_begin,
  output logic [7:0]  scfsi,
  output logic [11:0] gc_part2_3_length,
  output logic [8:0]  gc_big_values,
  output logic [7:0]  gc_global_gain,
  output logic        gc_window_switching_flag,
  output logic [1:0]  gc_block_type,
  output logic [4:0]  gc_table_select0,
  output logic [3:0]  gc_region0_count
);

  logic [mp3_pkg::si_bytes*8-1:0] si_sr;
  logic [mp3_pkg::si_bytes*8-1:0] si_next;
  logic [4:0]                     byte_cnt;
  mp3_pkg::gc_info_t [0:3]        gc_hold;   // gr0ch0 in the top bits
  mp3_pkg::gc_info_t              gc;
  mp3_pkg::region_t               region;

  assign si_next = {si_sr[mp3_pkg::si_bytes*8-9:0], sec_byte};

  always_ff @(posedge clk_100mhz) begin
    if (si_strobe)
      si_sr <= si_next;
  end

  ////////////////////////////////////////
  // Capture on the last side-info byte

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      byte_cnt        <= '0;
      si_valid        <= 1'b0;
      main_data_begin <= '0;
      scfsi           <= '0;
      gc_hold         <= '0;
    end else begin
      si_valid <= 1'b0;
      if (si_strobe) begin
        byte_cnt <= byte_cnt + 5'd1;
        if (byte_cnt == 5'(mp3_pkg::si_bytes - 1)) begin
          si_valid        <= 1'b1;
          main_data_begin <= si_next[255:247];
          // Bits 246:244 are private_bits, not kept
          scfsi           <= si_next[243:236];
          gc_hold         <= si_next[235:0];
        end
      end
    end
  end

  ////////////////////////////////////////
  // Readback of one record

  assign gc     = gc_hold[gc_sel];
  assign region = gc.region;

  assign gc_part2_3_length        = gc.part2_3_length;
  assign gc_big_values            = gc.big_values;
  assign gc_global_gain           = gc.global_gain;
  assign gc_window_switching_flag = gc.window_switching_flag;

  always_comb begin
    if (gc.window_switching_flag) begin
      gc_block_type    = region.sw.block_type;
      gc_table_select0 = region.sw.table_select[0];
      gc_region0_count = 4'd7;                   // Implied for switched blocks
    end else begin
      gc_block_type    = 2'd0;
      gc_table_select0 = region.lg.table_select[0];
      gc_region0_count = region.lg.region0_count;
    end
  end

endmodule

`default_nettype wire

// File: hw/frame_demux.sv
`default_nettype none
`timescale 1ns/1ps

module frame_demux (
  input  wire         clk_100mhz,
  input  wire         sys_rst,
  input  wire  [7:0]  byte_in,
  input  wire         byte_valid,
  header_if.demux     hdr,
  output logic        frame_start,
  output logic [1:0]  mode,
  output logic [1:0]  mode_ext,
  output logic        prot,
  output logic [10:0] frame_size,
  output logic [7:0]  sec_byte,
  output logic        si_strobe,
  output logic        md_strobe
);

  logic        busy;      // Inside a frame body
  logic [10:0] byte_cnt;  // Bytes after the header
  logic        accept;
  logic        prot_now;
  logic [10:0] idx;
  logic [10:0] body_len;
  logic [10:0] si_first;
  logic [10:0] md_first;

  // Headers seen mid-frame are sync patterns in main data
  assign accept = ~busy & hdr.hdr_valid;

  // On the accept cycle the new header applies to the byte already present
  assign prot_now = accept ? hdr.prot : prot;
  assign idx      = accept ? 11'd0 : byte_cnt;
  assign body_len = (accept ? hdr.frame_size : frame_size) - 11'(mp3_pkg::hdr_bytes);
  assign si_first = prot_now ? 11'(mp3_pkg::crc_bytes) : 11'd0;
  assign md_first = si_first + 11'(mp3_pkg::si_bytes);

  ////////////////////////////////////////
  // Frame tracking and section marking

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      busy        <= 1'b0;
      byte_cnt    <= '0;
      frame_start <= 1'b0;
      si_strobe   <= 1'b0;
      md_strobe   <= 1'b0;
      mode        <= '0;
      mode_ext    <= '0;
      prot        <= 1'b0;
      frame_size  <= '0;
    end else begin
      frame_start <= accept;
      si_strobe   <= 1'b0;
      md_strobe   <= 1'b0;

      if (accept) begin
        busy       <= 1'b1;
        byte_cnt   <= '0;
        mode       <= hdr.mode;
        mode_ext   <= hdr.mode_ext;
        prot       <= hdr.prot;
        frame_size <= hdr.frame_size;
      end

      if (byte_valid && (busy || accept)) begin
        si_strobe <= (idx >= si_first) && (idx < md_first);
        md_strobe <= idx >= md_first;                   // CRC bytes get neither
        byte_cnt  <= idx + 11'd1;
        if (idx + 11'd1 == body_len)
          busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (byte_valid)
      sec_byte <= byte_in;
  end

endmodule

`default_nettype wire

// File: hw/header_finder.sv
`default_nettype none
`timescale 1ns/1ps

module header_finder (
  input  wire        clk_100mhz,
  input  wire        sys_rst,
  input  wire  [7:0] byte_in,
  input  wire        byte_valid,
  header_if.finder   hdr
);

  logic [31:0] window;
  logic [31:0] win_next;
  logic [3:0]  br_idx;
  logic [1:0]  sr_idx;
  logic [8:0]  kbps;
  logic [10:0] base_size;
  logic        match;

  assign win_next = {window[23:0], byte_in};
  assign br_idx   = win_next[15:12];
  assign sr_idx   = win_next[11:10];

  always_comb begin
    kbps = (br_idx == 4'hf) ? 9'd0 : mp3_pkg::bitrate_kbps[br_idx];

    // 144 * rate / fs reduces to shifts at 48 and 32 kHz
    if (sr_idx == 2'b01)
      base_size = {kbps, 1'b0} + 11'(kbps);             // 3 x rate
    else
      base_size = {kbps, 2'b00} + 11'(kbps[8:1]);       // 4.5 x rate, floor

    match = (win_next[31:21] == mp3_pkg::sync_word)
         && (win_next[20:19] == 2'b11)                  // MPEG-1
         && (win_next[18:17] == 2'b01)                  // Layer III
         && (br_idx != 4'h0) && (br_idx != 4'hf)
         && ((sr_idx == 2'b01) || (sr_idx == 2'b10))
         && (win_next[7:6] != 2'b11);                   // No mono
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      window        <= '0;
      hdr.hdr_valid <= 1'b0;
    end else begin
      hdr.hdr_valid <= 1'b0;
      if (byte_valid) begin
        window        <= win_next;
        hdr.hdr_valid <= match;
      end
    end
  end

  // Decoded fields, only meaningful with hdr_valid
  always_ff @(posedge clk_100mhz) begin
    if (byte_valid && match) begin
      hdr.prot       <= ~win_next[16];                  // Protection bit is active low
      hdr.mode       <= win_next[7:6];
      hdr.mode_ext   <= win_next[5:4];
      hdr.emphasis   <= win_next[1:0];
      hdr.frame_size <= base_size + 11'(win_next[9]);   // Padding slot
    end
  end

endmodule

`default_nettype wire

// File: hw/header_if.sv
`default_nettype none
`timescale 1ns/1ps

interface header_if;

  logic        hdr_valid;   // Single cycle pulse
  logic        prot;        // CRC word follows the header
  logic [1:0]  mode;
  logic [1:0]  mode_ext;
  logic [1:0]  emphasis;
  logic [10:0] frame_size;  // Whole frame, header included

  modport finder (
    output hdr_valid, prot, mode, mode_ext, emphasis, frame_size
  );

  modport demux (
    input hdr_valid, prot, mode, mode_ext, emphasis, frame_size
  );

endinterface

`default_nettype wire

// File: hw/mp3_pkg.sv
`default_nettype none

package mp3_pkg;

  ////////////////////////////////////////
  // Stream constants

  localparam logic [10:0] sync_word = 11'h7ff;
  localparam int          hdr_bytes = 4;
  localparam int          crc_bytes = 2;
  localparam int          si_bytes  = 32;  // Stereo side information only

  // Layer III bitrates, index 0 is free format
  localparam logic [14:0][8:0] bitrate_kbps = {
    9'd320, 9'd256, 9'd224, 9'd192, 9'd160, 9'd128, 9'd112, 9'd96,
    9'd80,  9'd64,  9'd56,  9'd48,  9'd40,  9'd32,  9'd0
  };

  ////////////////////////////////////////
  // Granule/channel record

  // Region part when window_switching_flag is set
  typedef struct packed {
    logic [1:0]      block_type;
    logic            mixed_block_flag;
    logic [0:1][4:0] table_select;   // Region 0 first in the stream
    logic [0:2][2:0] subblock_gain;
  } switched_t;

  // Region part for normal long blocks
  typedef struct packed {
    logic [0:2][4:0] table_select;
    logic [3:0]      region0_count;
    logic [2:0]      region1_count;
  } long_t;

  typedef union packed {
    switched_t sw;
    long_t     lg;
  } region_t;

  // Fields in stream order, first field in the top bits
  typedef struct packed {
    logic [11:0] part2_3_length;
    logic [8:0]  big_values;
    logic [7:0]  global_gain;
    logic [3:0]  scalefac_compress;
    logic        window_switching_flag;
    region_t     region;
    logic        preflag;
    logic        scalefac_scale;
    logic        count1table_select;
  } gc_info_t;

endpackage

`default_nettype wire
